//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // ======================================================================
    // Opcodes of the supported RV32I subset
    // ======================================================================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Operand source for execute
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EM,
        FWD_MW
    } fwd_sel_e;

    // ======================================================================
    // Stage payloads
    // ======================================================================
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fd_payload_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [4:0]  rs1_idx;
        logic [4:0]  rs2_idx;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        br_ne;
        logic        is_jal;
        logic        reg_we;
        logic [4:0]  rd;
    } de_payload_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] result;
        logic [31:0] store_data;
        logic        is_load;
        logic        is_store;
        logic        reg_we;
        logic [4:0]  rd;
    } em_payload_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        reg_we;
        logic [4:0]  rd;
        logic [31:0] result;
    } mw_payload_t;

    // Register file write port, also the oldest forwarding source
    typedef struct packed {
        logic        en;
        logic [4:0]  idx;
        logic [31:0] data;
    } wb_port_t;

endpackage

`default_nettype wire

//--- logic/fetch_stage.sv
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire                   stall_i,
    input  wire                   flush_i,
    input  wire                   redirect_i,
    input  wire  [31:0]           redirect_pc_i,
    output logic [31:0]           imem_addr_o,
    input  wire  [31:0]           imem_data_i,
    output core_pkg::fd_payload_t fd_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_d;

    // Redirect from execute wins over a load-use hold
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (stall_i) begin
            pc_d = pc_q;
        end else begin
            pc_d = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // Instruction memory answers in the same cycle
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            fd_o.valid <= 1'b0;
        end else if (!stall_i) begin
            fd_o <= '{valid: 1'b1, pc: pc_q, instr: imem_data_i};
        end
    end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire                   stall_i,
    input  wire                   flush_i,
    input  wire core_pkg::fd_payload_t fd_i,
    input  wire core_pkg::wb_port_t    wb_i,
    output logic [4:0]            rs1_idx_o,
    output logic [4:0]            rs2_idx_o,
    output core_pkg::de_payload_t de_o
);

    logic [31:0]           regs [32];
    logic [31:0]           instr;
    logic                  use_rs1;
    logic                  use_rs2;
    core_pkg::de_payload_t de_d;

    assign instr = fd_i.instr;

    // Write-first read, x0 hardwired to zero
    function automatic logic [31:0] read_rf(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 32'd0;
        end
        if (wb_i.en && wb_i.idx == idx) begin
            return wb_i.data;
        end
        return regs[idx];
    endfunction

    // ======================================================================
    // Decoder and immediates
    // ======================================================================
    always_comb begin
        de_d        = '0;
        de_d.valid  = fd_i.valid;
        de_d.pc     = fd_i.pc;
        de_d.rd     = instr[11:7];
        de_d.alu_op = core_pkg::ALU_ADD;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (instr[6:0])
            core_pkg::OPC_OP: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                de_d.reg_we = 1'b1;
                case ({instr[31:25], instr[14:12]})
                    10'b0000000_000: de_d.alu_op = core_pkg::ALU_ADD;
                    10'b0100000_000: de_d.alu_op = core_pkg::ALU_SUB;
                    10'b0000000_111: de_d.alu_op = core_pkg::ALU_AND;
                    10'b0000000_110: de_d.alu_op = core_pkg::ALU_OR;
                    10'b0000000_100: de_d.alu_op = core_pkg::ALU_XOR;
                    10'b0000000_010: de_d.alu_op = core_pkg::ALU_SLT;
                    default: begin
                        use_rs1     = 1'b0;
                        use_rs2     = 1'b0;
                        de_d.reg_we = 1'b0;
                    end
                endcase
            end
            core_pkg::OPC_OPIMM: begin
                // ADDI only
                use_rs1      = (instr[14:12] == 3'b000);
                de_d.reg_we  = use_rs1;
                de_d.use_imm = 1'b1;
                de_d.imm     = {{20{instr[31]}}, instr[31:20]};
            end
            core_pkg::OPC_LUI: begin
                de_d.reg_we  = 1'b1;
                de_d.use_imm = 1'b1;
                de_d.alu_op  = core_pkg::ALU_PASS_B;
                de_d.imm     = {instr[31:12], 12'd0};
            end
            core_pkg::OPC_LOAD: begin
                use_rs1      = (instr[14:12] == 3'b010);
                de_d.is_load = use_rs1;
                de_d.reg_we  = use_rs1;
                de_d.use_imm = 1'b1;
                de_d.imm     = {{20{instr[31]}}, instr[31:20]};
            end
            core_pkg::OPC_STORE: begin
                use_rs1       = (instr[14:12] == 3'b010);
                use_rs2       = use_rs1;
                de_d.is_store = use_rs1;
                de_d.use_imm  = 1'b1;
                de_d.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            core_pkg::OPC_BRANCH: begin
                // BEQ and BNE differ in funct3 bit 0
                use_rs1        = (instr[14:13] == 2'b00);
                use_rs2        = use_rs1;
                de_d.is_branch = use_rs1;
                de_d.br_ne     = instr[12];
                de_d.imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            end
            core_pkg::OPC_JAL: begin
                de_d.is_jal = 1'b1;
                de_d.reg_we = 1'b1;
                de_d.imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
            end
            default: ;
        endcase
        if (de_d.rd == 5'd0) begin
            de_d.reg_we = 1'b0;
        end
        de_d.rs1_idx = (use_rs1 && fd_i.valid) ? instr[19:15] : 5'd0;
        de_d.rs2_idx = (use_rs2 && fd_i.valid) ? instr[24:20] : 5'd0;
        de_d.rs1_val = read_rf(de_d.rs1_idx);
        de_d.rs2_val = read_rf(de_d.rs2_idx);
    end

    assign rs1_idx_o = de_d.rs1_idx;
    assign rs2_idx_o = de_d.rs2_idx;

    // ======================================================================
    // Register file and decode-to-execute register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (wb_i.en && wb_i.idx != 5'd0) begin
            regs[wb_i.idx] <= wb_i.data;
        end
    end

    always_ff @(posedge clk) begin
        de_o <= de_d;
        // Bubble on load-use hold, squash on redirect
        // An empty slot never carries a branch or a jump
        if (rst_i || flush_i || stall_i || !fd_i.valid) begin
            de_o.valid     <= 1'b0;
            de_o.is_branch <= 1'b0;
            de_o.is_jal    <= 1'b0;
        end
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
        wb_i.en |-> wb_i.idx != 5'd0);

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire core_pkg::de_payload_t de_i,
    input  wire core_pkg::fwd_sel_e    fwd_a_i,
    input  wire core_pkg::fwd_sel_e    fwd_b_i,
    input  wire core_pkg::em_payload_t em_fwd_i,
    input  wire core_pkg::wb_port_t    wb_i,
    output logic                       redirect_o,
    output logic [31:0]                redirect_pc_o,
    output core_pkg::em_payload_t      em_o
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_res;

    function automatic logic [31:0] pick_operand(input core_pkg::fwd_sel_e sel,
                                                 input logic [31:0] rf_val);
        case (sel)
            core_pkg::FWD_EM: return em_fwd_i.result;
            core_pkg::FWD_MW: return wb_i.data;
            default:          return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a = pick_operand(fwd_a_i, de_i.rs1_val);
        op_b = pick_operand(fwd_b_i, de_i.rs2_val);
    end

    assign alu_b = de_i.use_imm ? de_i.imm : op_b;

    always_comb begin
        case (de_i.alu_op)
            core_pkg::ALU_SUB:    alu_res = op_a - alu_b;
            core_pkg::ALU_AND:    alu_res = op_a & alu_b;
            core_pkg::ALU_OR:     alu_res = op_a | alu_b;
            core_pkg::ALU_XOR:    alu_res = op_a ^ alu_b;
            core_pkg::ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
            core_pkg::ALU_PASS_B: alu_res = alu_b;
            default:              alu_res = op_a + alu_b;
        endcase
    end

    // Taken branch or JAL, resolved here with not-taken assumed upstream
    assign redirect_o = de_i.is_jal ||
                        (de_i.is_branch && ((op_a == op_b) != de_i.br_ne));
    assign redirect_pc_o = de_i.pc + de_i.imm;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            em_o.valid    <= 1'b0;
            em_o.reg_we   <= 1'b0;
            em_o.is_load  <= 1'b0;
            em_o.is_store <= 1'b0;
        end else begin
            em_o.valid    <= de_i.valid;
            em_o.reg_we   <= de_i.valid && de_i.reg_we;
            em_o.is_load  <= de_i.valid && de_i.is_load;
            em_o.is_store <= de_i.valid && de_i.is_store;
        end
        em_o.pc         <= de_i.pc;
        em_o.result     <= de_i.is_jal ? de_i.pc + 32'd4 : alu_res;
        em_o.store_data <= op_b;
        em_o.rd         <= de_i.rd;
    end

    a_redirect_valid: assert property (@(posedge clk) disable iff (rst_i)
        redirect_o |-> de_i.valid);

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire core_pkg::em_payload_t em_i,
    output core_pkg::wb_port_t         wb_o,
    output logic                       retire_valid_o,
    output logic [31:0]                retire_pc_o,
    output logic                       retire_we_o,
    output logic [4:0]                 retire_rd_o,
    output logic [31:0]                retire_data_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]           dmem [DMEM_WORDS];
    logic [AW-1:0]         word_idx;
    core_pkg::mw_payload_t mw_q;

    // Word address from the ALU sum
    assign word_idx = em_i.result[AW+1:2];

    // Store lands at the end of its memory cycle
    always_ff @(posedge clk) begin
        if (em_i.valid && em_i.is_store) begin
            dmem[word_idx] <= em_i.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mw_q.valid  <= 1'b0;
            mw_q.reg_we <= 1'b0;
        end else begin
            mw_q.valid  <= em_i.valid;
            mw_q.reg_we <= em_i.valid && em_i.reg_we;
        end
        mw_q.pc     <= em_i.pc;
        mw_q.rd     <= em_i.rd;
        mw_q.result <= em_i.is_load ? dmem[word_idx] : em_i.result;
    end

    // ======================================================================
    // Writeback and retire
    // ======================================================================
    assign wb_o = '{en: mw_q.reg_we, idx: mw_q.rd, data: mw_q.result};

    assign retire_valid_o = mw_q.valid;
    assign retire_pc_o    = mw_q.pc;
    assign retire_we_o    = mw_q.reg_we;
    assign retire_rd_o    = mw_q.rd;
    assign retire_data_o  = mw_q.result;

    a_word_aligned: assert property (@(posedge clk) disable iff (rst_i)
        em_i.valid && (em_i.is_load || em_i.is_store) |-> em_i.result[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire [4:0]                  rs1_idx_i,
    input  wire [4:0]                  rs2_idx_i,
    input  wire core_pkg::de_payload_t de_i,
    input  wire core_pkg::em_payload_t em_i,
    input  wire core_pkg::wb_port_t    wb_i,
    input  wire                        redirect_i,
    output logic                       stall_o,
    output logic                       flush_fd_o,
    output logic                       flush_de_o,
    output core_pkg::fwd_sel_e         fwd_a_o,
    output core_pkg::fwd_sel_e         fwd_b_o
);

    // Younger result in the memory stage wins
    function automatic core_pkg::fwd_sel_e pick_src(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return core_pkg::FWD_RF;
        end
        if (em_i.valid && em_i.reg_we && em_i.rd == idx) begin
            return core_pkg::FWD_EM;
        end
        if (wb_i.en && wb_i.idx == idx) begin
            return core_pkg::FWD_MW;
        end
        return core_pkg::FWD_RF;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(de_i.rs1_idx);
        fwd_b_o = pick_src(de_i.rs2_idx);
    end

    // Load data is not ready until the memory stage, so hold one cycle
    assign stall_o = de_i.valid && de_i.is_load && de_i.rd != 5'd0 &&
                     (de_i.rd == rs1_idx_i || de_i.rd == rs2_idx_i);

    assign flush_fd_o = redirect_i;
    assign flush_de_o = redirect_i || stall_o;

    a_stall_vs_redirect: assert property (@(posedge clk) disable iff (rst_i)
        !(stall_o && redirect_i));

endmodule

`default_nettype wire

//--- logic/core_top.sv
`default_nettype none

module core_top #(
    parameter logic [31:0] RESET_PC   = 32'h0000_0000,
    parameter int          DMEM_WORDS = 256
) (
    input  wire         clk,
    input  wire         rst_i,
    output logic [31:0] imem_addr_o,
    input  wire  [31:0] imem_data_i,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic        retire_we_o,
    output logic [4:0]  retire_rd_o,
    output logic [31:0] retire_data_o
);

    // Stage boundaries
    core_pkg::fd_payload_t fd;
    core_pkg::de_payload_t de;
    core_pkg::em_payload_t em;
    core_pkg::wb_port_t    wb;

    // Control between the stages and the hazard unit
    logic                 redirect;
    logic [31:0]          redirect_pc;
    logic                 stall;
    logic                 flush_fd;
    logic                 flush_de;
    logic [4:0]           rs1_idx;
    logic [4:0]           rs2_idx;
    core_pkg::fwd_sel_e   fwd_a;
    core_pkg::fwd_sel_e   fwd_b;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (stall),
        .flush_i       (flush_fd),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .fd_o          (fd)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_i     (rst_i),
        .stall_i   (stall),
        .flush_i   (flush_de),
        .fd_i      (fd),
        .wb_i      (wb),
        .rs1_idx_o (rs1_idx),
        .rs2_idx_o (rs2_idx),
        .de_o      (de)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_i         (rst_i),
        .de_i          (de),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .em_fwd_i      (em),
        .wb_i          (wb),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .em_o          (em)
    );

    memory_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_memory (
        .clk            (clk),
        .rst_i          (rst_i),
        .em_i           (em),
        .wb_o           (wb),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    hazard_unit u_hazard (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .de_i       (de),
        .em_i       (em),
        .wb_i       (wb),
        .redirect_i (redirect),
        .stall_o    (stall),
        .flush_fd_o (flush_fd),
        .flush_de_o (flush_de),
        .fwd_a_o    (fwd_a),
        .fwd_b_o    (fwd_b)
    );

endmodule

`default_nettype wire

//--- testbench/core_tb.sv
`default_nettype none

module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC     = 32'h0000_0000;
    localparam int          DMEM_WORDS   = 256;
    localparam int          PROG_WORDS   = 128;
    localparam int          LAST_IDX     = PROG_WORDS - 1;
    localparam logic [31:0] LAST_PC      = RESET_PC + 32'(LAST_IDX * 4);
    localparam int          NUM_PROGS    = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          WATCHDOG_CYCLES = NUM_PROGS * (PROG_WORDS * 20 + RESET_CYCLES + 2);

    logic        clk;
    logic        rst_i = 1'b1;
    logic        rst_q = 1'b0;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic        retire_we_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] lfsr_q = 32'haea1_92ae;

    // Reference model state
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [DMEM_WORDS];
    int          m_count = 0;
    logic        prog_done = 1'b0;

    // Model's view of the instruction due to retire next
    logic [31:0] cur;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic [31:0] exp_next;
    logic        exp_store;
    logic [31:0] exp_addr;
    logic [31:0] exp_sdata;

    core_top #(
        .RESET_PC   (RESET_PC),
        .DMEM_WORDS (DMEM_WORDS)
    ) dut0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    // Program memory answers in the same cycle, addresses wrap
    assign imem_data = prog[imem_addr[8:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Failure reporting
    // ======================================================================
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // ======================================================================
    // Random program generator
    // ======================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::OPC_JAL};
    endfunction

    // funct7 and funct3 of the R-type ALU operations
    function automatic logic [9:0] r_funct(input logic [2:0] sel);
        case (sel)
            3'd0:    return 10'b0000000_000;
            3'd1:    return 10'b0100000_000;
            3'd2:    return 10'b0000000_111;
            3'd3:    return 10'b0000000_110;
            3'd4:    return 10'b0000000_100;
            default: return 10'b0000000_010;
        endcase
    endfunction

    task automatic build_program();
        int          idx;
        int          skip;
        logic [31:0] kind;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [9:0]  fn;
        logic [11:0] off;
        idx = 0;
        // Seed x1..x7, then the first 16 data words
        for (int k = 1; k < 8; k++) begin
            r = rand_bits(12);
            prog[idx] = {r[11:0], 5'd0, 3'b000, 5'(k), core_pkg::OPC_OPIMM};
            idx++;
        end
        for (int k = 0; k < 16; k++) begin
            off = 12'(k * 4);
            prog[idx] = {off[11:5], 5'(k % 7 + 1), 5'd0, 3'b010, off[4:0],
                         core_pkg::OPC_STORE};
            idx++;
        end
        while (idx < LAST_IDX - 4) begin
            kind = rand_bits(4);
            rd   = 5'(rand_bits(3));
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            skip = int'(rand_bits(2)) + 1;
            case (kind[3:0])
                4'd6, 4'd7: begin
                    r = rand_bits(12);
                    prog[idx] = {r[11:0], rs1, 3'b000, rd, core_pkg::OPC_OPIMM};
                end
                4'd8: begin
                    r = rand_bits(20);
                    prog[idx] = {r[19:0], rd, core_pkg::OPC_LUI};
                end
                4'd9: begin
                    // Load with its consumer right behind it
                    if (rd == 5'd0) begin
                        rd = 5'd1;
                    end
                    r = rand_bits(4);
                    prog[idx] = {6'd0, r[3:0], 2'b00, 5'd0, 3'b010, rd, core_pkg::OPC_LOAD};
                    idx++;
                    prog[idx] = {7'd0, rs2, rd, 3'b000, rs1, core_pkg::OPC_OP};
                end
                4'd10: begin
                    r = rand_bits(4);
                    off = {6'd0, r[3:0], 2'b00};
                    prog[idx] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], core_pkg::OPC_STORE};
                end
                4'd11, 4'd12: begin
                    prog[idx] = enc_b(13'((skip + 1) * 4), rs2, rs1, {2'b00, kind[0]});
                end
                4'd13: begin
                    prog[idx] = enc_j(21'((skip + 1) * 4), rd);
                end
                4'd14: begin
                    // MUL, SLLI, FENCE and LH all fall outside the subset
                    r = rand_bits(2);
                    case (r[1:0])
                        2'd0: prog[idx] = {7'b0000001, rs2, rs1, 3'b000, rd, core_pkg::OPC_OP};
                        2'd1: prog[idx] = {7'd0, 5'd3, rs1, 3'b001, rd, core_pkg::OPC_OPIMM};
                        2'd2: prog[idx] = 32'h0ff0_000f;
                        default: prog[idx] = {12'd8, 5'd0, 3'b001, rd, core_pkg::OPC_LOAD};
                    endcase
                end
                default: begin
                    fn = r_funct(3'(rand_bits(3)));
                    prog[idx] = {fn[9:3], rs2, rs1, fn[2:0], rd, core_pkg::OPC_OP};
                end
            endcase
            idx++;
        end
        while (idx < LAST_IDX) begin
            prog[idx] = 32'h0000_0013;
            idx++;
        end
        // Park on a jump to itself
        prog[LAST_IDX] = enc_j(21'd0, 5'd0);
    endtask

    // ======================================================================
    // Instruction-set reference model
    // ======================================================================
    always_comb begin
        cur       = prog[m_pc[8:2]];
        rs1v      = m_regs[cur[19:15]];
        rs2v      = m_regs[cur[24:20]];
        imm_i     = {{20{cur[31]}}, cur[31:20]};
        imm_s     = {{20{cur[31]}}, cur[31:25], cur[11:7]};
        imm_b     = {{19{cur[31]}}, cur[31], cur[7], cur[30:25], cur[11:8], 1'b0};
        imm_j     = {{11{cur[31]}}, cur[31], cur[19:12], cur[20], cur[30:21], 1'b0};
        exp_rd    = cur[11:7];
        exp_we    = 1'b0;
        exp_data  = '0;
        exp_next  = m_pc + 32'd4;
        exp_store = 1'b0;
        exp_addr  = rs1v + imm_i;
        exp_sdata = rs2v;
        case (cur[6:0])
            core_pkg::OPC_OP: begin
                exp_we = 1'b1;
                case ({cur[31:25], cur[14:12]})
                    10'b0000000_000: exp_data = rs1v + rs2v;
                    10'b0100000_000: exp_data = rs1v - rs2v;
                    10'b0000000_111: exp_data = rs1v & rs2v;
                    10'b0000000_110: exp_data = rs1v | rs2v;
                    10'b0000000_100: exp_data = rs1v ^ rs2v;
                    10'b0000000_010: exp_data = ($signed(rs1v) < $signed(rs2v)) ? 32'd1 : 32'd0;
                    default:         exp_we = 1'b0;
                endcase
            end
            core_pkg::OPC_OPIMM: begin
                exp_we   = (cur[14:12] == 3'b000);
                exp_data = rs1v + imm_i;
            end
            core_pkg::OPC_LUI: begin
                exp_we   = 1'b1;
                exp_data = {cur[31:12], 12'd0};
            end
            core_pkg::OPC_LOAD: begin
                exp_we   = (cur[14:12] == 3'b010);
                exp_data = m_mem[exp_addr[9:2]];
            end
            core_pkg::OPC_STORE: begin
                exp_store = (cur[14:12] == 3'b010);
                exp_addr  = rs1v + imm_s;
            end
            core_pkg::OPC_BRANCH: begin
                if ((cur[14:12] == 3'b000 && rs1v == rs2v) ||
                    (cur[14:12] == 3'b001 && rs1v != rs2v)) begin
                    exp_next = m_pc + imm_b;
                end
            end
            core_pkg::OPC_JAL: begin
                exp_we   = 1'b1;
                exp_data = m_pc + 32'd4;
                exp_next = m_pc + imm_j;
            end
            default: ;
        endcase
        if (exp_rd == 5'd0) begin
            exp_we = 1'b0;
        end
    end

    // Model advances one instruction per retire
    always_ff @(posedge clk) begin
        rst_q <= rst_i;
        if (rst_i) begin
            m_pc      <= RESET_PC;
            m_count   <= 0;
            prog_done <= 1'b0;
            m_regs[0] <= '0;
        end else if (retire_valid_o) begin
            m_pc    <= exp_next;
            m_count <= m_count + 1;
            if (exp_we) begin
                m_regs[exp_rd] <= exp_data;
            end
            if (exp_store) begin
                m_mem[exp_addr[9:2]] <= exp_sdata;
            end
            if (m_pc == LAST_PC) begin
                prog_done <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Retire checks
    // ======================================================================
    a_retire_pc: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o |-> retire_pc_o == m_pc)
        else report_mismatch("retire_pc_o", $sampled(retire_pc_o), $sampled(m_pc));

    a_retire_we: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o |-> retire_we_o == exp_we)
        else report_mismatch("retire_we_o", 32'($sampled(retire_we_o)), 32'($sampled(exp_we)));

    a_retire_rd: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o && exp_we |-> retire_rd_o == exp_rd)
        else report_mismatch("retire_rd_o", 32'($sampled(retire_rd_o)), 32'($sampled(exp_rd)));

    a_retire_data: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o && exp_we |-> retire_data_o == exp_data)
        else report_mismatch("retire_data_o", $sampled(retire_data_o), $sampled(exp_data));

    a_x0_no_write: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o && retire_rd_o == 5'd0 |-> !retire_we_o)
        else report_mismatch("retire_we_o", 32'($sampled(retire_we_o)), 32'd0);

    a_first_pc: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o && m_count == 0 |-> retire_pc_o == RESET_PC)
        else report_mismatch("retire_pc_o", $sampled(retire_pc_o), RESET_PC);

    // Quiet once the reset has been seen by one edge
    a_reset_quiet: assert property (@(posedge clk)
        rst_i && rst_q |-> !retire_valid_o)
        else report_mismatch("retire_valid_o", 32'($sampled(retire_valid_o)), 32'd0);

    // ======================================================================
    // Stimulus and watchdog
    // ======================================================================
    initial begin : main
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(posedge clk);
            rst_i <= 1'b1;
            @(posedge clk);
            build_program();
            repeat (RESET_CYCLES - 1) @(posedge clk);
            rst_i <= 1'b0;
            while (!prog_done) begin
                @(posedge clk);
            end
        end
        $display("** PASS **");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Timeout, the core stopped retiring before the programs completed");
    end

endmodule

`default_nettype wire

//--- flist.f
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/core_top.sv
testbench/core_tb.sv

//--- Makefile
# Verilator build for the five-stage core and its testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
